// File: hdl/mem_if_pkg.sv
// ----------------------------------------
// Banked memory interface definitions
// ----------------------------------------

package mem_if_pkg;

   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 64;
   localparam int NUM_BYTES = 8;
   localparam int OFFSET_W  = 3;
   localparam int NB_BANKS  = 4;
   localparam int BANK_W    = 2;
   localparam int ROW_W     = 13;
   localparam int ID_W      = 4;

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [NUM_BYTES-1:0] strb_t;
   typedef logic [ID_W-1:0]      id_t;
   typedef logic [BANK_W-1:0]    bank_t;
   typedef logic [ROW_W-1:0]     row_t;

   // ----------------------------------------
   // AXI side payloads
   // ----------------------------------------
   typedef struct packed {
      id_t   id;
      addr_t addr;
      data_t data;
      strb_t strb;
   } wr_req_t;

   typedef struct packed {
      id_t   id;
      addr_t addr;
   } rd_req_t;

   typedef struct packed {
      id_t  id;
      logic err;
   } wr_rsp_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      logic  err;
   } rd_rsp_t;

   // Controller request towards the crossbar
   typedef struct packed {
      bank_t bank;
      row_t  row;
      data_t data;
      strb_t be;
   } bank_req_t;

   typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RSP} wr_state_t;
   typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_RSP} rd_state_t;

endpackage

// File: hdl/axi_write_ctrl.sv
// ----------------------------------------
// Single-beat AXI write controller
// ----------------------------------------

module axi_write_ctrl
(
   input  logic                  aclk_i,
   input  logic                  rst_i,
   input  mem_if_pkg::wr_req_t   req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   output mem_if_pkg::wr_rsp_t   rsp_o,
   output logic                  rsp_valid_o,
   input  logic                  rsp_ready_i,
   output mem_if_pkg::bank_req_t bank_req_o,
   output logic                  bank_req_valid_o,
   input  logic                  bank_gnt_i
);

   mem_if_pkg::wr_state_t state_q;
   mem_if_pkg::wr_state_t state_d;
   mem_if_pkg::bank_req_t bank_req_q;
   mem_if_pkg::wr_rsp_t   rsp_q;
   logic                  accept;
   logic                  addr_ok;

   assign accept = req_valid_i & req_ready_o;

   // Legal only below the top of the banked range
   assign addr_ok = (req_i.addr[mem_if_pkg::ADDR_W-1:
                                mem_if_pkg::OFFSET_W+mem_if_pkg::BANK_W+mem_if_pkg::ROW_W] == '0);

   // ----------------------------------------
   // State machine
   // ----------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         mem_if_pkg::WR_IDLE:
            if (accept)
               state_d = addr_ok ? mem_if_pkg::WR_REQ : mem_if_pkg::WR_RSP;
         mem_if_pkg::WR_REQ:
            if (bank_gnt_i)
               state_d = mem_if_pkg::WR_RSP;
         mem_if_pkg::WR_RSP:
            if (rsp_ready_i)
               state_d = mem_if_pkg::WR_IDLE;
         default:
            state_d = mem_if_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         state_q <= mem_if_pkg::WR_IDLE;
      else
         state_q <= state_d;
   end

   // Split the address into bank and row on acceptance
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         bank_req_q.bank <= req_i.addr[mem_if_pkg::OFFSET_W +: mem_if_pkg::BANK_W];
         bank_req_q.row  <= req_i.addr[mem_if_pkg::OFFSET_W+mem_if_pkg::BANK_W +:
                                       mem_if_pkg::ROW_W];
         bank_req_q.data <= req_i.data;
         bank_req_q.be   <= req_i.strb;
         rsp_q.id        <= req_i.id;
         rsp_q.err       <= ~addr_ok;
      end
   end

   assign req_ready_o      = (state_q == mem_if_pkg::WR_IDLE);
   assign bank_req_valid_o = (state_q == mem_if_pkg::WR_REQ);
   assign rsp_valid_o      = (state_q == mem_if_pkg::WR_RSP);
   assign bank_req_o       = bank_req_q;
   assign rsp_o            = rsp_q;

endmodule

// File: hdl/axi_read_ctrl.sv
// ----------------------------------------
// Single-beat AXI read controller
// ----------------------------------------

module axi_read_ctrl
(
   input  logic                  aclk_i,
   input  logic                  rst_i,
   input  mem_if_pkg::rd_req_t   req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   output mem_if_pkg::rd_rsp_t   rsp_o,
   output logic                  rsp_valid_o,
   input  logic                  rsp_ready_i,
   output mem_if_pkg::bank_req_t bank_req_o,
   output logic                  bank_req_valid_o,
   input  logic                  bank_gnt_i,
   input  mem_if_pkg::data_t     bank_rdata_i,
   input  logic                  bank_rvalid_i
);

   mem_if_pkg::rd_state_t state_q;
   mem_if_pkg::rd_state_t state_d;
   mem_if_pkg::bank_req_t bank_req_q;
   mem_if_pkg::rd_rsp_t   rsp_q;
   logic                  accept;
   logic                  addr_ok;

   assign accept  = req_valid_i & req_ready_o;
   assign addr_ok = (req_i.addr[mem_if_pkg::ADDR_W-1:
                                mem_if_pkg::OFFSET_W+mem_if_pkg::BANK_W+mem_if_pkg::ROW_W] == '0);

   // ----------------------------------------
   // State machine
   // ----------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         mem_if_pkg::RD_IDLE:
            if (accept)
               state_d = addr_ok ? mem_if_pkg::RD_REQ : mem_if_pkg::RD_RSP;
         mem_if_pkg::RD_REQ:
            if (bank_gnt_i)
               state_d = mem_if_pkg::RD_WAIT;
         // Bank data arrives one cycle after the grant
         mem_if_pkg::RD_WAIT:
            if (bank_rvalid_i)
               state_d = mem_if_pkg::RD_RSP;
         mem_if_pkg::RD_RSP:
            if (rsp_ready_i)
               state_d = mem_if_pkg::RD_IDLE;
         default:
            state_d = mem_if_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         state_q <= mem_if_pkg::RD_IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         bank_req_q.bank <= req_i.addr[mem_if_pkg::OFFSET_W +: mem_if_pkg::BANK_W];
         bank_req_q.row  <= req_i.addr[mem_if_pkg::OFFSET_W+mem_if_pkg::BANK_W +:
                                       mem_if_pkg::ROW_W];
         bank_req_q.data <= '0;
         bank_req_q.be   <= '0;
         rsp_q.id        <= req_i.id;
         rsp_q.data      <= '0;
         rsp_q.err       <= ~addr_ok;
      end
      else if (state_q == mem_if_pkg::RD_WAIT && bank_rvalid_i)
         rsp_q.data <= bank_rdata_i;
   end

   assign req_ready_o      = (state_q == mem_if_pkg::RD_IDLE);
   assign bank_req_valid_o = (state_q == mem_if_pkg::RD_REQ);
   assign rsp_valid_o      = (state_q == mem_if_pkg::RD_RSP);
   assign bank_req_o       = bank_req_q;
   assign rsp_o            = rsp_q;

endmodule

// File: hdl/bank_xbar.sv
// ----------------------------------------
// Write/read bank crossbar
// ----------------------------------------

module bank_xbar
(
   input  logic                                          aclk_i,
   input  logic                                          rst_i,
   input  mem_if_pkg::bank_req_t                         wr_req_i,
   input  logic                                          wr_valid_i,
   output logic                                          wr_gnt_o,
   input  mem_if_pkg::bank_req_t                         rd_req_i,
   input  logic                                          rd_valid_i,
   output logic                                          rd_gnt_o,
   output mem_if_pkg::data_t                             rd_rdata_o,
   output logic                                          rd_rvalid_o,
   output logic [mem_if_pkg::NB_BANKS-1:0]               bank_cen_o,
   output logic [mem_if_pkg::NB_BANKS-1:0]               bank_wen_o,
   output mem_if_pkg::row_t  [mem_if_pkg::NB_BANKS-1:0]  bank_addr_o,
   output mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0]  bank_wdata_o,
   output mem_if_pkg::strb_t [mem_if_pkg::NB_BANKS-1:0]  bank_be_o,
   input  mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0]  bank_q_i
);

   // One bit per bank, set means the read side wins the next conflict
   logic [mem_if_pkg::NB_BANKS-1:0] rd_prio_q;
   logic                            conflict;
   mem_if_pkg::bank_t               rd_bank_q;
   logic                            rvalid_q;

   // ----------------------------------------
   // Arbitration
   // ----------------------------------------
   assign conflict = wr_valid_i & rd_valid_i & (wr_req_i.bank == rd_req_i.bank);

   assign wr_gnt_o = wr_valid_i & (~conflict | ~rd_prio_q[wr_req_i.bank]);
   assign rd_gnt_o = rd_valid_i & (~conflict |  rd_prio_q[rd_req_i.bank]);

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         rd_prio_q <= '0;
      else if (conflict)
         rd_prio_q[wr_req_i.bank] <= ~rd_prio_q[wr_req_i.bank];
   end

   // ----------------------------------------
   // Bank drive
   // ----------------------------------------
   always_comb
   begin
      for (int b = 0; b < mem_if_pkg::NB_BANKS; b++)
      begin
         bank_cen_o[b]   = 1'b1;
         bank_wen_o[b]   = 1'b1;
         bank_addr_o[b]  = '0;
         bank_wdata_o[b] = '0;
         bank_be_o[b]    = '0;
         // Grants never collide on one bank
         if (wr_gnt_o && wr_req_i.bank == mem_if_pkg::bank_t'(b))
         begin
            bank_cen_o[b]   = 1'b0;
            bank_wen_o[b]   = 1'b0;
            bank_addr_o[b]  = wr_req_i.row;
            bank_wdata_o[b] = wr_req_i.data;
            bank_be_o[b]    = wr_req_i.be;
         end
         else if (rd_gnt_o && rd_req_i.bank == mem_if_pkg::bank_t'(b))
         begin
            bank_cen_o[b]  = 1'b0;
            bank_addr_o[b] = rd_req_i.row;
         end
      end
   end

   // ----------------------------------------
   // Read return
   // ----------------------------------------
   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         rvalid_q <= 1'b0;
      else
         rvalid_q <= rd_gnt_o;
   end

   always_ff @(posedge aclk_i)
   begin
      if (rd_gnt_o)
         rd_bank_q <= rd_req_i.bank;
   end

   assign rd_rvalid_o = rvalid_q;
   assign rd_rdata_o  = bank_q_i[rd_bank_q];

endmodule

// File: hdl/mem_if_top.sv
// ----------------------------------------
// Banked memory interface top level
// ----------------------------------------

module mem_if_top
(
   input  logic                                          aclk_i,
   input  logic                                          rst_i,
   input  mem_if_pkg::wr_req_t                           wr_req_i,
   input  logic                                          wr_req_valid_i,
   output logic                                          wr_req_ready_o,
   output mem_if_pkg::wr_rsp_t                           wr_rsp_o,
   output logic                                          wr_rsp_valid_o,
   input  logic                                          wr_rsp_ready_i,
   input  mem_if_pkg::rd_req_t                           rd_req_i,
   input  logic                                          rd_req_valid_i,
   output logic                                          rd_req_ready_o,
   output mem_if_pkg::rd_rsp_t                           rd_rsp_o,
   output logic                                          rd_rsp_valid_o,
   input  logic                                          rd_rsp_ready_i,
   output logic [mem_if_pkg::NB_BANKS-1:0]               bank_cen_o,
   output logic [mem_if_pkg::NB_BANKS-1:0]               bank_wen_o,
   output mem_if_pkg::row_t  [mem_if_pkg::NB_BANKS-1:0]  bank_addr_o,
   output mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0]  bank_wdata_o,
   output mem_if_pkg::strb_t [mem_if_pkg::NB_BANKS-1:0]  bank_be_o,
   input  mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0]  bank_q_i
);

   mem_if_pkg::bank_req_t wr_bank_req;
   mem_if_pkg::bank_req_t rd_bank_req;
   logic                  wr_bank_valid;
   logic                  wr_bank_gnt;
   logic                  rd_bank_valid;
   logic                  rd_bank_gnt;
   mem_if_pkg::data_t     rd_bank_rdata;
   logic                  rd_bank_rvalid;

   axi_write_ctrl axi_write_ctrl_inst
   (
      .aclk_i           ( aclk_i         ),
      .rst_i            ( rst_i          ),
      .req_i            ( wr_req_i       ),
      .req_valid_i      ( wr_req_valid_i ),
      .req_ready_o      ( wr_req_ready_o ),
      .rsp_o            ( wr_rsp_o       ),
      .rsp_valid_o      ( wr_rsp_valid_o ),
      .rsp_ready_i      ( wr_rsp_ready_i ),
      .bank_req_o       ( wr_bank_req    ),
      .bank_req_valid_o ( wr_bank_valid  ),
      .bank_gnt_i       ( wr_bank_gnt    )
   );

   axi_read_ctrl axi_read_ctrl_inst
   (
      .aclk_i           ( aclk_i         ),
      .rst_i            ( rst_i          ),
      .req_i            ( rd_req_i       ),
      .req_valid_i      ( rd_req_valid_i ),
      .req_ready_o      ( rd_req_ready_o ),
      .rsp_o            ( rd_rsp_o       ),
      .rsp_valid_o      ( rd_rsp_valid_o ),
      .rsp_ready_i      ( rd_rsp_ready_i ),
      .bank_req_o       ( rd_bank_req    ),
      .bank_req_valid_o ( rd_bank_valid  ),
      .bank_gnt_i       ( rd_bank_gnt    ),
      .bank_rdata_i     ( rd_bank_rdata  ),
      .bank_rvalid_i    ( rd_bank_rvalid )
   );

   // Write side and read side merged onto the banks
   bank_xbar bank_xbar_inst
   (
      .aclk_i       ( aclk_i         ),
      .rst_i        ( rst_i          ),
      .wr_req_i     ( wr_bank_req    ),
      .wr_valid_i   ( wr_bank_valid  ),
      .wr_gnt_o     ( wr_bank_gnt    ),
      .rd_req_i     ( rd_bank_req    ),
      .rd_valid_i   ( rd_bank_valid  ),
      .rd_gnt_o     ( rd_bank_gnt    ),
      .rd_rdata_o   ( rd_bank_rdata  ),
      .rd_rvalid_o  ( rd_bank_rvalid ),
      .bank_cen_o   ( bank_cen_o     ),
      .bank_wen_o   ( bank_wen_o     ),
      .bank_addr_o  ( bank_addr_o    ),
      .bank_wdata_o ( bank_wdata_o   ),
      .bank_be_o    ( bank_be_o      ),
      .bank_q_i     ( bank_q_i       )
   );

endmodule

// File: bench/mem_if_props.sv
// ----------------------------------------
// Interface protocol checks
// ----------------------------------------

module mem_if_props
(
   input  logic                                 aclk_i,
   input  logic                                 rst_i,
   input  mem_if_pkg::wr_req_t                  wr_req_i,
   input  logic                                 wr_req_valid_i,
   input  logic                                 wr_req_ready_i,
   input  mem_if_pkg::wr_rsp_t                  wr_rsp_i,
   input  logic                                 wr_rsp_valid_i,
   input  logic                                 wr_rsp_ready_i,
   input  mem_if_pkg::rd_req_t                  rd_req_i,
   input  logic                                 rd_req_valid_i,
   input  logic                                 rd_req_ready_i,
   input  mem_if_pkg::rd_rsp_t                  rd_rsp_i,
   input  logic                                 rd_rsp_valid_i,
   input  logic                                 rd_rsp_ready_i,
   input  logic [mem_if_pkg::NB_BANKS-1:0]      bank_cen_i,
   input  logic                                 wr_gnt_i,
   input  logic                                 rd_gnt_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // Responses held stable until taken
   wr_rsp_hold: assert property (@(posedge aclk_i) disable iff (rst_i)
      wr_rsp_valid_i && !wr_rsp_ready_i |=> wr_rsp_valid_i && $stable(wr_rsp_i))
      else $error("write response dropped or changed while ready was low");

   rd_rsp_hold: assert property (@(posedge aclk_i) disable iff (rst_i)
      rd_rsp_valid_i && !rd_rsp_ready_i |=> rd_rsp_valid_i && $stable(rd_rsp_i))
      else $error("read response dropped or changed while ready was low");

   // One active bank per grant, none without a grant
   cen_per_gnt: assert property (@(posedge aclk_i) disable iff (rst_i)
      $countones(~bank_cen_i) == int'(wr_gnt_i) + int'(rd_gnt_i))
      else $error("bank enables do not match the crossbar grants");

   // Out-of-range requests skip the banks and answer at once
   wr_decode_skip: assert property (@(posedge aclk_i) disable iff (rst_i)
      wr_req_valid_i && wr_req_ready_i &&
      (wr_req_i.addr >> (mem_if_pkg::OFFSET_W + mem_if_pkg::BANK_W + mem_if_pkg::ROW_W)) != 0
      |=> !wr_gnt_i && wr_rsp_valid_i)
      else $error("out-of-range write reached a bank or was not answered");

   rd_decode_skip: assert property (@(posedge aclk_i) disable iff (rst_i)
      rd_req_valid_i && rd_req_ready_i &&
      (rd_req_i.addr >> (mem_if_pkg::OFFSET_W + mem_if_pkg::BANK_W + mem_if_pkg::ROW_W)) != 0
      |=> !rd_gnt_i && rd_rsp_valid_i)
      else $error("out-of-range read reached a bank or was not answered");

   rsp_idle_after_rst: assert property (@(posedge aclk_i)
      $fell(rst_i) |-> !wr_rsp_valid_i && !rd_rsp_valid_i)
      else $error("response valid high right after reset");

endmodule

bind mem_if_top mem_if_props mem_if_props_inst
(
   .aclk_i         ( aclk_i         ),
   .rst_i          ( rst_i          ),
   .wr_req_i       ( wr_req_i       ),
   .wr_req_valid_i ( wr_req_valid_i ),
   .wr_req_ready_i ( wr_req_ready_o ),
   .wr_rsp_i       ( wr_rsp_o       ),
   .wr_rsp_valid_i ( wr_rsp_valid_o ),
   .wr_rsp_ready_i ( wr_rsp_ready_i ),
   .rd_req_i       ( rd_req_i       ),
   .rd_req_valid_i ( rd_req_valid_i ),
   .rd_req_ready_i ( rd_req_ready_o ),
   .rd_rsp_i       ( rd_rsp_o       ),
   .rd_rsp_valid_i ( rd_rsp_valid_o ),
   .rd_rsp_ready_i ( rd_rsp_ready_i ),
   .bank_cen_i     ( bank_cen_o     ),
   .wr_gnt_i       ( wr_bank_gnt    ),
   .rd_gnt_i       ( rd_bank_gnt    )
);

// File: bench/mem_if_tb.sv
// ----------------------------------------
// Banked memory interface testbench
// ----------------------------------------

module mem_if_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 20;
   localparam int N_WORDS    = 16;
   // Upper bound on transactions and cycles per transaction
   localparam int MAX_OPS    = 80;
   localparam int OP_CYCLES  = 12;

   logic                                         aclk;
   logic                                         rst;
   mem_if_pkg::wr_req_t                          wr_req;
   logic                                         wr_req_valid;
   logic                                         wr_req_ready;
   mem_if_pkg::wr_rsp_t                          wr_rsp;
   logic                                         wr_rsp_valid;
   logic                                         wr_rsp_ready;
   mem_if_pkg::rd_req_t                          rd_req;
   logic                                         rd_req_valid;
   logic                                         rd_req_ready;
   mem_if_pkg::rd_rsp_t                          rd_rsp;
   logic                                         rd_rsp_valid;
   logic                                         rd_rsp_ready;
   logic [mem_if_pkg::NB_BANKS-1:0]              bank_cen;
   logic [mem_if_pkg::NB_BANKS-1:0]              bank_wen;
   mem_if_pkg::row_t  [mem_if_pkg::NB_BANKS-1:0] bank_addr;
   mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0] bank_wdata;
   mem_if_pkg::strb_t [mem_if_pkg::NB_BANKS-1:0] bank_be;
   mem_if_pkg::data_t [mem_if_pkg::NB_BANKS-1:0] bank_q;

   mem_if_pkg::data_t bank_mem [mem_if_pkg::NB_BANKS][2**mem_if_pkg::ROW_W];
   // Expected memory contents, keyed by word address
   mem_if_pkg::data_t ref_mem [mem_if_pkg::addr_t];
   integer            seed = 32'he3e0904d;
   int                tests;
   int                checks;
   int                errors;

   mem_if_top mem_if_top_inst
   (
      .aclk_i         ( aclk         ),
      .rst_i          ( rst          ),
      .wr_req_i       ( wr_req       ),
      .wr_req_valid_i ( wr_req_valid ),
      .wr_req_ready_o ( wr_req_ready ),
      .wr_rsp_o       ( wr_rsp       ),
      .wr_rsp_valid_o ( wr_rsp_valid ),
      .wr_rsp_ready_i ( wr_rsp_ready ),
      .rd_req_i       ( rd_req       ),
      .rd_req_valid_i ( rd_req_valid ),
      .rd_req_ready_o ( rd_req_ready ),
      .rd_rsp_o       ( rd_rsp       ),
      .rd_rsp_valid_o ( rd_rsp_valid ),
      .rd_rsp_ready_i ( rd_rsp_ready ),
      .bank_cen_o     ( bank_cen     ),
      .bank_wen_o     ( bank_wen     ),
      .bank_addr_o    ( bank_addr    ),
      .bank_wdata_o   ( bank_wdata   ),
      .bank_be_o      ( bank_be      ),
      .bank_q_i       ( bank_q       )
   );

   initial
   begin
      aclk = 1'b0;
      forever #(CLK_PERIOD/2) aclk = ~aclk;
   end

   // ----------------------------------------
   // Reference helpers
   // ----------------------------------------
   function automatic mem_if_pkg::data_t fill_word(input mem_if_pkg::addr_t a);
      return {a, ~a};
   endfunction

   function automatic mem_if_pkg::addr_t word_of(input mem_if_pkg::addr_t a);
      return {a[mem_if_pkg::ADDR_W-1:mem_if_pkg::OFFSET_W], 3'b000};
   endfunction

   // Legal when every bit above the row field is zero
   function automatic logic in_range(input mem_if_pkg::addr_t a);
      return (a >> (mem_if_pkg::OFFSET_W + mem_if_pkg::BANK_W + mem_if_pkg::ROW_W)) == 0;
   endfunction

   function automatic mem_if_pkg::data_t expect_word(input mem_if_pkg::addr_t a);
      if (ref_mem.exists(word_of(a)))
         return ref_mem[word_of(a)];
      return fill_word(word_of(a));
   endfunction

   function automatic mem_if_pkg::data_t merge_bytes(input mem_if_pkg::data_t old_w,
                                                     input mem_if_pkg::data_t new_w,
                                                     input mem_if_pkg::strb_t strb);
      mem_if_pkg::data_t res;
      res = old_w;
      for (int k = 0; k < mem_if_pkg::NUM_BYTES; k++)
         if (strb[k])
            res[8*k +: 8] = new_w[8*k +: 8];
      return res;
   endfunction

   // ----------------------------------------
   // Bank model
   // ----------------------------------------
   initial
   begin
      bank_q = '0;
      for (int b = 0; b < mem_if_pkg::NB_BANKS; b++)
         for (int r = 0; r < 2**mem_if_pkg::ROW_W; r++)
            bank_mem[b][r] = fill_word(mem_if_pkg::addr_t'({mem_if_pkg::row_t'(r),
                                                            mem_if_pkg::bank_t'(b), 3'b000}));
   end

   // q shows the old word one cycle after the access
   always @(posedge aclk)
   begin
      for (int b = 0; b < mem_if_pkg::NB_BANKS; b++)
      begin
         if (!bank_cen[b])
         begin
            bank_q[b] <= bank_mem[b][bank_addr[b]];
            if (!bank_wen[b])
               for (int k = 0; k < mem_if_pkg::NUM_BYTES; k++)
                  if (bank_be[b][k])
                     bank_mem[b][bank_addr[b]][8*k +: 8] = bank_wdata[b][8*k +: 8];
         end
      end
   end

   // ----------------------------------------
   // Handshake and check tasks
   // ----------------------------------------
   task automatic check(input logic ok, input string what);
      checks++;
      assert (ok)
      else
      begin
         errors++;
         $display("ERR %0t: %s", $time, what);
      end
   endtask

   task automatic send_wr(input mem_if_pkg::wr_req_t req);
      @(negedge aclk);
      wr_req       = req;
      wr_req_valid = 1'b1;
      while (!wr_req_ready)
         @(negedge aclk);
      @(negedge aclk);
      wr_req_valid = 1'b0;
   endtask

   task automatic send_rd(input mem_if_pkg::rd_req_t req);
      @(negedge aclk);
      rd_req       = req;
      rd_req_valid = 1'b1;
      while (!rd_req_ready)
         @(negedge aclk);
      @(negedge aclk);
      rd_req_valid = 1'b0;
   endtask

   task automatic wr_txn(input mem_if_pkg::id_t id, input mem_if_pkg::addr_t addr,
                         input mem_if_pkg::data_t data, input mem_if_pkg::strb_t strb);
      mem_if_pkg::wr_req_t req;
      mem_if_pkg::wr_rsp_t rsp;
      req.id   = id;
      req.addr = addr;
      req.data = data;
      req.strb = strb;
      send_wr(req);
      while (!wr_rsp_valid)
         @(negedge aclk);
      rsp = wr_rsp;
      @(negedge aclk);
      check(rsp.id == id && rsp.err == !in_range(addr),
            $sformatf("write addr %h rsp id %h err %b, expected id %h err %b",
                      addr, rsp.id, rsp.err, id, !in_range(addr)));
      if (in_range(addr))
         ref_mem[word_of(addr)] = merge_bytes(expect_word(addr), data, strb);
   endtask

   task automatic rd_txn(input mem_if_pkg::id_t id, input mem_if_pkg::addr_t addr);
      mem_if_pkg::rd_req_t req;
      mem_if_pkg::rd_rsp_t rsp;
      mem_if_pkg::data_t   exp;
      exp      = expect_word(addr);
      req.id   = id;
      req.addr = addr;
      send_rd(req);
      while (!rd_rsp_valid)
         @(negedge aclk);
      rsp = rd_rsp;
      @(negedge aclk);
      check(rsp.id == id && rsp.err == !in_range(addr),
            $sformatf("read addr %h rsp id %h err %b, expected id %h err %b",
                      addr, rsp.id, rsp.err, id, !in_range(addr)));
      if (in_range(addr))
         check(rsp.data == exp,
               $sformatf("read addr %h data %h, expected %h", addr, rsp.data, exp));
   endtask

   task automatic wr_rd_pair(input mem_if_pkg::addr_t waddr, input mem_if_pkg::addr_t raddr);
      mem_if_pkg::data_t wdata;
      wdata = {$random(seed), $random(seed)};
      fork
         wr_txn(4'h6, waddr, wdata, '1);
         rd_txn(4'h7, raddr);
      join
   endtask

   task automatic report_test(input string name, input int start_errs);
      tests++;
      $display("Test %-14s finished with %0d errors", name, errors - start_errs);
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------
   task automatic test_write_read();
      int start;
      start = errors;
      for (int i = 0; i < N_WORDS; i++)
         wr_txn(mem_if_pkg::id_t'(i), mem_if_pkg::addr_t'(32'h1000 + 8*i),
                {$random(seed), $random(seed)}, '1);
      for (int i = 0; i < N_WORDS; i++)
         rd_txn(mem_if_pkg::id_t'(i), mem_if_pkg::addr_t'(32'h1000 + 8*i));
      report_test("write_read", start);
   endtask

   task automatic test_strobes();
      mem_if_pkg::strb_t strb_list [4];
      int                start;
      start     = errors;
      strb_list = '{8'h0F, 8'hA0, 8'h01, 8'h3C};
      wr_txn(4'h1, 32'h0000_2010, {$random(seed), $random(seed)}, '1);
      for (int i = 0; i < 4; i++)
      begin
         wr_txn(4'h2, 32'h0000_2010, {$random(seed), $random(seed)}, strb_list[i]);
         rd_txn(4'h3, 32'h0000_2010);
      end
      report_test("strobes", start);
   endtask

   task automatic test_decode_error();
      int start;
      start = errors;
      wr_txn(4'hA, 32'h0004_1008, {$random(seed), $random(seed)}, '1);
      rd_txn(4'hB, 32'h8000_0000);
      // Alias of the rejected write must be untouched
      rd_txn(4'hC, 32'h0000_1008);
      report_test("decode_error", start);
   endtask

   task automatic test_concurrent();
      int start;
      start = errors;
      wr_rd_pair(32'h0000_3000, 32'h0000_1008);
      // Same bank, different rows, both priority outcomes
      wr_rd_pair(32'h0000_3020, 32'h0000_1000);
      wr_rd_pair(32'h0000_3040, 32'h0000_1020);
      wr_rd_pair(32'h0000_3050, 32'h0000_1010);
      rd_txn(4'h8, 32'h0000_3000);
      rd_txn(4'h9, 32'h0000_3020);
      rd_txn(4'hA, 32'h0000_3040);
      rd_txn(4'hB, 32'h0000_3050);
      report_test("concurrent", start);
   endtask

   task automatic test_backpressure();
      mem_if_pkg::wr_req_t wreq;
      mem_if_pkg::rd_req_t rreq;
      mem_if_pkg::wr_rsp_t wrsp;
      mem_if_pkg::rd_rsp_t rrsp;
      mem_if_pkg::data_t   rexp;
      int                  start;
      start = errors;
      rexp  = expect_word(32'h0000_1018);
      wreq  = '{id: 4'h3, addr: 32'h0000_4008, data: {$random(seed), $random(seed)}, strb: '1};
      rreq  = '{id: 4'h4, addr: 32'h0000_1018};
      @(negedge aclk);
      wr_rsp_ready = 1'b0;
      rd_rsp_ready = 1'b0;
      fork
         send_wr(wreq);
         send_rd(rreq);
      join
      while (!(wr_rsp_valid && rd_rsp_valid))
         @(negedge aclk);
      wrsp = wr_rsp;
      rrsp = rd_rsp;
      repeat (6)
      begin
         @(negedge aclk);
         check(wr_rsp_valid && rd_rsp_valid && wr_rsp == wrsp && rd_rsp == rrsp,
               $sformatf("response changed under back-pressure, wr %h rd %h", wr_rsp, rd_rsp));
         check(!wr_req_ready && !rd_req_ready, "request ready high under back-pressure");
      end
      check(wrsp.id == 4'h3 && !wrsp.err, $sformatf("held write rsp %h", wrsp));
      check(rrsp.id == 4'h4 && !rrsp.err && rrsp.data == rexp,
            $sformatf("held read rsp id %h data %h, expected %h", rrsp.id, rrsp.data, rexp));
      wr_rsp_ready = 1'b1;
      rd_rsp_ready = 1'b1;
      @(negedge aclk);
      check(!wr_rsp_valid && !rd_rsp_valid, "response valid still high after release");
      ref_mem[word_of(wreq.addr)] = wreq.data;
      rd_txn(4'h5, 32'h0000_4008);
      report_test("backpressure", start);
   endtask

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------
   initial
   begin
      rst          = 1'b1;
      wr_req       = '0;
      wr_req_valid = 1'b0;
      wr_rsp_ready = 1'b1;
      rd_req       = '0;
      rd_req_valid = 1'b0;
      rd_rsp_ready = 1'b1;
      repeat (4) @(posedge aclk);
      @(negedge aclk);
      rst = 1'b0;
      test_write_read();
      test_strobes();
      test_decode_error();
      test_concurrent();
      test_backpressure();
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      #(CLK_PERIOD * (MAX_OPS * OP_CYCLES + 20));
      $display("Watchdog expired before the tests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: all.f
hdl/mem_if_pkg.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/bank_xbar.sv
hdl/mem_if_top.sv
bench/mem_if_props.sv
bench/mem_if_tb.sv

// File: Makefile
# Verilator build and run of the banked memory interface testbench

TOP := mem_if_tb

all: run

obj_dir/V$(TOP): all.f $(wildcard hdl/*.sv bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
